// File: all.f
common/i2c_redir_pkg.sv
src/i2c_line_sync.sv
i2c_redir/i2c_bus_fsm.sv
i2c_redir/i2c_drive_ctrl.sv
src/i2c_redirector.sv
verif/tb_clock_gen.sv
verif/i2c_redirector_sva.sv
verif/tb_i2c_redirector.sv

// File: Bender.yml
package:
  name: i2c_redirector

sources:
  - common/i2c_redir_pkg.sv
  - src/i2c_line_sync.sv
  - i2c_redir/i2c_bus_fsm.sv
  - i2c_redir/i2c_drive_ctrl.sv
  - src/i2c_redirector.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/i2c_redirector_sva.sv
      - verif/tb_i2c_redirector.sv

// File: verif/tb_i2c_redirector.sv
// Testbench for the I2C redirector; runs idle, write, read, STOP and error recovery cases.
`timescale 1ns/1ps

module tb_i2c_redirector;
    import i2c_redir_pkg::*;

    localparam int slot_len    = byte_bits + 1;
    localparam int total_bits  = 3 * slot_len * 3 + 40; // Three transfers plus idle and error.
    localparam int timeout_ns  = total_bits * 80 * 10 * 2;

    logic          aclk;
    logic          aresetn;
    wire           scl0, sda0, scl1, sda1;
    redir_status_t status;
    logic          drv_scl [2]; // Set means the model pulls the line low.
    logic          drv_sda [2];
    logic [31:0]   lcg_state;
    logic [35:0]   exp_vec;
    logic [7:0]    cur_addr;
    side_e         cur_side;
    int            cur_slot;
    int            err_count;
    int            check_count;
    event          mid_high;

    pullup (scl0);
    pullup (sda0);
    pullup (scl1);
    pullup (sda1);
    assign scl0 = drv_scl[0] ? 1'b0 : 1'bz;
    assign sda0 = drv_sda[0] ? 1'b0 : 1'bz;
    assign scl1 = drv_scl[1] ? 1'b0 : 1'bz;
    assign sda1 = drv_sda[1] ? 1'b0 : 1'bz;

    tb_clock_gen u_clk (.aclk(aclk), .aresetn(aresetn));

    i2c_redirector #(.sync_stages(2)) UUT (
        .scl0(scl0), .sda0(sda0), .scl1(scl1), .sda1(sda1),
        .aclk(aclk), .aresetn(aresetn), .status(status)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected SDA per slot, address first, each byte followed by its ACK.
    function automatic logic [35:0] ref_sda(input logic [7:0] addr, input logic [23:0] wdata,
                                            input logic [23:0] rdata, input int nbytes);
        logic [35:0] v;
        logic [7:0]  b;
        v = '1;
        for (int k = 0; k <= nbytes; k++) begin
            b = (k == 0) ? addr : (addr[0] ? rdata[8*(k-1) +: 8] : wdata[8*(k-1) +: 8]);
            for (int i = 0; i < byte_bits; i++) v[k*slot_len + i] = b[byte_bits-1-i];
            v[k*slot_len + byte_bits] = (k > 0 && addr[0] && k == nbytes); // Last read NACK.
        end
        return v;
    endfunction

    function automatic redir_status_t ref_status(input side_e m, input logic [7:0] addr,
                                                 input int slot);
        return '{busy: 1'b1, master: m, rw: (slot >= byte_bits) ? addr[0] : 1'b0};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_side(input string name, input side_e got, input side_e exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_status(input string name, input redir_status_t got,
                                input redir_status_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    always @(mid_high) begin
        check_bit("sda0", sda0, exp_vec[cur_slot]);
        check_bit("sda1", sda1, exp_vec[cur_slot]);
        check_status("status", status, ref_status(cur_side, cur_addr, cur_slot));
        check_side("status.master", status.master, cur_side);
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    task automatic quiet_window(input int cycles, input int p);
        for (int c = 0; c < cycles; c++) begin
            wait_cycles(1);
            check_bit(p ? "scl1" : "scl0", p ? scl1 : scl0, 1'b1);
            check_bit(p ? "sda1" : "sda0", p ? sda1 : sda0, 1'b1);
        end
    endtask

    // One SCL period from the falling edge; slot below zero skips the check.
    task automatic clock_slot(input int m, input logic m_bit, input logic s_bit, input int slot);
        wait_cycles(10);
        drv_sda[m]     = !m_bit;
        drv_sda[1 - m] = !s_bit;
        wait_cycles(30);
        drv_scl[m] = 1'b0;
        wait_cycles(20);
        if (slot >= 0) begin
            cur_slot = slot;
            -> mid_high;
        end
        wait_cycles(20);
        drv_scl[m] = 1'b1;
    endtask

    task automatic bus_start(input int m);
        wait_cycles(20);
        drv_sda[m] = 1'b1;
        wait_cycles(40);
        check_status("status", status, ref_status(side_e'(m), 8'h00, 0));
        drv_scl[m] = 1'b1;
    endtask

    task automatic bus_stop(input int m);
        wait_cycles(10);
        drv_sda[m]     = 1'b1;
        drv_sda[1 - m] = 1'b0;
        wait_cycles(30);
        drv_scl[m] = 1'b0;
        wait_cycles(20);
        drv_sda[m] = 1'b0;
        wait_cycles(20);
        check_status("status", status, '0);
        quiet_window(4, 0);
        quiet_window(4, 1);
    endtask

    task automatic run_transfer(input side_e m, input logic rd, input int nbytes);
        logic [23:0] wdata;
        logic [23:0] rdata;
        int          mi;
        lcg_state = lcg_next(lcg_state);
        cur_addr  = {lcg_state[23:17], rd};
        lcg_state = lcg_next(lcg_state);
        wdata     = lcg_state[31:8];
        lcg_state = lcg_next(lcg_state);
        rdata     = lcg_state[31:8];
        cur_side  = m;
        mi        = int'(m);
        exp_vec   = ref_sda(cur_addr, wdata, rdata, nbytes);
        bus_start(mi);
        for (int s = 0; s <= nbytes * slot_len + byte_bits; s++) begin
            if (s < byte_bits) clock_slot(mi, exp_vec[s], 1'b1, s);
            else if (s % slot_len == byte_bits && (s == byte_bits || !rd))
                clock_slot(mi, 1'b1, 1'b0, s); // Slave ACK.
            else if (!rd) clock_slot(mi, exp_vec[s], 1'b1, s);
            else if (s % slot_len == byte_bits) clock_slot(mi, exp_vec[s], 1'b1, s);
            else clock_slot(mi, 1'b1, exp_vec[s], s);
        end
        bus_stop(mi);
    endtask

    initial begin
        #(timeout_ns);
        $display("Watchdog expired before the tests completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        drv_scl     = '{1'b0, 1'b0};
        drv_sda     = '{1'b0, 1'b0};
        lcg_state   = 32'hd86bb9ae;
        err_count   = 0;
        check_count = 0;
        cur_slot    = 0;
        exp_vec     = '1;
        @(posedge aresetn);
        wait_cycles(10);
        check_status("status", status, '0);
        drv_scl[0] = 1'b1; // SDA toggles only while SCL is low.
        wait_cycles(10);
        drv_sda[0] = 1'b1;
        quiet_window(20, 1);
        drv_sda[0] = 1'b0;
        quiet_window(10, 1);
        drv_scl[0] = 1'b0;
        quiet_window(20, 1);
        check_status("status", status, '0);

        run_transfer(side_port0, 1'b0, 2);
        run_transfer(side_port1, 1'b1, 2);

        // Mid-byte START puts the core into its error state.
        lcg_state = lcg_next(lcg_state);
        bus_start(0);
        for (int s = 0; s < 3; s++) clock_slot(0, lcg_state[s], 1'b1, -1);
        wait_cycles(10);
        drv_sda[0] = 1'b0;
        wait_cycles(30);
        drv_scl[0] = 1'b0;
        wait_cycles(20);
        drv_sda[0] = 1'b1;
        wait_cycles(20);
        drv_scl[0] = 1'b1;
        quiet_window(40, 1);
        drv_scl[0] = 1'b0;
        quiet_window(20, 1);
        drv_sda[0] = 1'b0; // STOP ends the error state.
        wait_cycles(20);
        check_status("status", status, '0);
        run_transfer(side_port0, 1'b0, 2);

        wait_cycles(10);
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/i2c_redirector_sva.sv
// Assertions on the redirector core; bound to every i2c_redirector instance.
`timescale 1ns/1ps

module i2c_redirector_sva (
    input logic                            aclk,
    input logic                            aresetn,
    input i2c_redir_pkg::bus_state_e       state,
    input i2c_redir_pkg::drive_t [1:0]     drive,
    input logic                            busy,
    input i2c_redir_pkg::bus_events_t      events
);
    import i2c_redir_pkg::*;

    a_state_legal: assert property (@(posedge aclk) disable iff (!aresetn)
        state inside {st_wait, st_start, st_addr, st_ack, st_data, st_stop, st_err})
        else $error("state left the enum");

    // Enables lag the state by one cycle.
    a_idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
        (state == st_wait && $past(state) == st_wait) |-> drive == '0)
        else $error("forwarding while idle");

    a_busy_active: assert property (@(posedge aclk) disable iff (!aresetn)
        events.start |=> ##1 (!busy || state != st_wait))
        else $error("busy with idle FSM");

    a_one_way: assert property (@(posedge aclk) disable iff (!aresetn)
        !(drive[0].scl_fwd && drive[1].scl_fwd) && !(drive[0].sda_fwd && drive[1].sda_fwd))
        else $error("line forwarded both ways");

endmodule

bind i2c_redirector i2c_redirector_sva u_sva (
    .aclk   (aclk),
    .aresetn(aresetn),
    .state  (state),
    .drive  (drive),
    .busy   (busy),
    .events (events)
);

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source; instantiated once by the testbench top.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 8
) (
    output logic aclk,
    output logic aresetn
);
    initial begin
        aclk    = 1'b0;
        aresetn = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #1 aresetn = 1'b1;
    end

    always #(period_ns / 2.0) aclk = ~aclk;

endmodule

// File: src/i2c_redirector.sv
// Top level of the I2C redirector joining two open-drain ports through the tracking core.
`timescale 1ns/1ps

module i2c_redirector #(
    parameter int sync_stages = 2
) (
    inout  wire                          scl0,
    inout  wire                          sda0,
    inout  wire                          scl1,
    inout  wire                          sda1,
    input  logic                         aclk,
    input  logic                         aresetn,
    output i2c_redir_pkg::redir_status_t status
);
    import i2c_redir_pkg::*;

    line_pair_t [1:0] pins;
    line_pair_t [1:0] sync;
    bus_events_t      events;
    bus_state_e       state;
    drive_t [1:0]     drive;
    logic             rw;
    logic             addr_ack;
    logic             busy;
    side_e            master;

    assign pins[0] = '{scl: scl0, sda: sda0};
    assign pins[1] = '{scl: scl1, sda: sda1};

    // Copy only the other port's low, never our own drive.
    assign scl0 = (drive[0].scl_fwd && !sync[1].scl) ? 1'b0 : 1'bz;
    assign sda0 = (drive[0].sda_fwd && !sync[1].sda) ? 1'b0 : 1'bz;
    assign scl1 = (drive[1].scl_fwd && !sync[0].scl) ? 1'b0 : 1'bz;
    assign sda1 = (drive[1].sda_fwd && !sync[0].sda) ? 1'b0 : 1'bz;

    i2c_line_sync #(
        .sync_stages(sync_stages)
    ) u_sync (
        .aclk   (aclk),
        .aresetn(aresetn),
        .pins   (pins),
        .sync   (sync),
        .events (events)
    );

    i2c_bus_fsm u_fsm (
        .aclk    (aclk),
        .aresetn (aresetn),
        .events  (events),
        .state   (state),
        .rw      (rw),
        .addr_ack(addr_ack)
    );

    i2c_drive_ctrl u_drive (
        .aclk    (aclk),
        .aresetn (aresetn),
        .state   (state),
        .rw      (rw),
        .addr_ack(addr_ack),
        .events  (events),
        .sync    (sync),
        .drive   (drive),
        .busy    (busy),
        .master  (master)
    );

    assign status = '{busy: busy, master: master, rw: rw};

endmodule

// File: i2c_redir/i2c_drive_ctrl.sv
// Holds busy and master side and registers the per-port SCL and SDA forward enables.
`timescale 1ns/1ps

module i2c_drive_ctrl (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  i2c_redir_pkg::bus_state_e       state,
    input  logic                            rw,
    input  logic                            addr_ack,
    input  i2c_redir_pkg::bus_events_t      events,
    input  i2c_redir_pkg::line_pair_t [1:0] sync,
    output i2c_redir_pkg::drive_t [1:0]     drive,
    output logic                            busy,
    output i2c_redir_pkg::side_e            master
);
    import i2c_redir_pkg::*;

    drive_t [1:0] drive_next;
    logic         fwd_en;
    logic         to_slave;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy   <= 1'b0;
            master <= side_port0;
        end else if (events.stop) begin
            busy   <= 1'b0;
            master <= side_port0;
        end else if (events.start) begin
            busy <= 1'b1;
            if (!busy) begin
                // Port holding SDA low opened the transaction.
                master <= sync[0].sda ? side_port1 : side_port0;
            end
        end
    end

    always_comb begin
        fwd_en = (state != st_wait) && (state != st_err);
        case (state)
            st_ack:  to_slave = !addr_ack && rw; // Master acks read data.
            st_data: to_slave = !rw;
            default: to_slave = 1'b1;            // START, address and STOP.
        endcase
        for (int p = 0; p < 2; p++) begin
            drive_next[p].scl_fwd = fwd_en && (master != side_e'(p));
            // Master port takes SDA only when the data flows toward it.
            drive_next[p].sda_fwd = fwd_en && ((master == side_e'(p)) ^ to_slave);
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            drive <= '0;
        end else begin
            drive <= drive_next;
        end
    end

endmodule

// File: i2c_redir/i2c_bus_fsm.sv
// Tracks START, address, ACK and data phases of the bus and captures the R/W bit.
`timescale 1ns/1ps

module i2c_bus_fsm (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  i2c_redir_pkg::bus_events_t events,
    output i2c_redir_pkg::bus_state_e  state,
    output logic                       rw,
    output logic                       addr_ack
);
    import i2c_redir_pkg::*;

    localparam int cnt_w = $clog2(byte_bits + 1);

    bus_state_e           next_state;
    logic [cnt_w-1:0]     bit_cnt;
    logic [byte_bits-1:0] shift_reg;
    logic                 in_byte;
    logic                 byte_end;
    logic                 restart_ok;

    assign in_byte    = (state == st_addr) || (state == st_data);
    assign byte_end   = events.scl_fall && (bit_cnt >= cnt_w'(byte_bits));
    // Repeated START may come after the ACK clock plus one SCL rise.
    assign restart_ok = bit_cnt <= cnt_w'(1);

    always_comb begin
        next_state = state;
        case (state)
            st_wait: begin
                if (events.start) next_state = st_start;
            end
            st_start: begin
                if (events.stop) next_state = st_stop;
                else if (events.scl_fall) next_state = st_addr;
            end
            st_addr, st_data: begin
                if (events.stop) next_state = st_stop;
                else if (events.start && restart_ok) next_state = st_start;
                else if (events.start) next_state = st_err;
                else if (byte_end) next_state = st_ack;
            end
            st_ack: begin
                if (events.stop) next_state = st_stop;
                else if (events.start) next_state = st_start;
                else if (events.scl_fall) next_state = st_data; // No 10-bit second byte.
            end
            st_stop: next_state = st_wait;
            st_err: begin
                if (events.stop) next_state = st_stop; // Hold off until the bus frees.
            end
            default: next_state = st_err;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= st_wait;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            bit_cnt <= '0;
        end else if (!in_byte) begin
            bit_cnt <= '0;
        end else if (events.scl_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // MSB first, so the R/W bit lands in bit 0.
    always_ff @(posedge aclk) begin
        if (!in_byte) begin
            shift_reg <= '0;
        end else if (events.scl_rise) begin
            shift_reg <= {shift_reg[byte_bits-2:0], events.sda};
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rw       <= 1'b0;
            addr_ack <= 1'b0;
        end else begin
            case (state)
                st_addr: begin
                    if (next_state == st_ack) begin
                        rw       <= shift_reg[0];
                        addr_ack <= 1'b1;
                    end
                end
                st_ack: begin
                    rw       <= rw;
                    addr_ack <= addr_ack;
                end
                st_data, st_stop: begin
                    addr_ack <= 1'b0; // Later ACKs belong to data.
                end
                default: begin
                    rw       <= 1'b0;
                    addr_ack <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: src/i2c_line_sync.sv
// Synchronizes both ports' SCL and SDA and derives bus level, edges, START and STOP.
`timescale 1ns/1ps

module i2c_line_sync #(
    parameter int sync_stages = 2
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  i2c_redir_pkg::line_pair_t [1:0] pins,
    output i2c_redir_pkg::line_pair_t [1:0] sync,
    output i2c_redir_pkg::bus_events_t      events
);
    import i2c_redir_pkg::*;

    logic [sync_stages:0] scl_chain [2]; // Top bit holds the previous sample.
    logic [sync_stages:0] sda_chain [2];

    logic scl_now;
    logic scl_last;
    logic sda_now;
    logic sda_last;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int p = 0; p < 2; p++) begin
                scl_chain[p] <= '1; // Idle bus is high.
                sda_chain[p] <= '1;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                scl_chain[p] <= {scl_chain[p][sync_stages-1:0], pins[p].scl};
                sda_chain[p] <= {sda_chain[p][sync_stages-1:0], pins[p].sda};
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            sync[p].scl = scl_chain[p][sync_stages-1];
            sync[p].sda = sda_chain[p][sync_stages-1];
        end
    end

    // Wired-AND of the two ports.
    assign scl_now  = sync[0].scl & sync[1].scl;
    assign sda_now  = sync[0].sda & sync[1].sda;
    assign scl_last = scl_chain[0][sync_stages] & scl_chain[1][sync_stages];
    assign sda_last = sda_chain[0][sync_stages] & sda_chain[1][sync_stages];

    always_comb begin
        events.scl_high = scl_now & scl_last;
        events.scl_rise = scl_now & !scl_last;
        events.scl_fall = !scl_now & scl_last;
        events.sda      = sda_now;
        events.start    = events.scl_high & sda_last & !sda_now;
        events.stop     = events.scl_high & !sda_last & sda_now;
    end

endmodule

// File: common/i2c_redir_pkg.sv
// Shared types and constants of the I2C redirector; imported by every block of the core.
package i2c_redir_pkg;

    localparam int byte_bits = 8; // Bits per I2C byte.

    // Transaction state of the redirector core.
    typedef enum logic [2:0] {
        st_wait  = 3'd0,
        st_start = 3'd1,
        st_addr  = 3'd2,
        st_ack   = 3'd3,
        st_data  = 3'd4,
        st_stop  = 3'd5,
        st_err   = 3'd6
    } bus_state_e;

    typedef enum logic {
        side_port0 = 1'b0,
        side_port1 = 1'b1
    } side_e;

    // Both lines of one port.
    typedef struct packed {
        logic scl;
        logic sda;
    } line_pair_t;

    typedef struct packed {
        logic start;    // SDA fall with SCL high.
        logic stop;     // SDA rise with SCL high.
        logic scl_rise;
        logic scl_fall;
        logic sda;      // Wired-AND level.
        logic scl_high; // High now and one cycle ago.
    } bus_events_t;

    // Forward enables of one port, set means the port copies the other side's low.
    typedef struct packed {
        logic scl_fwd;
        logic sda_fwd;
    } drive_t;

    typedef struct packed {
        logic  busy;
        side_e master;
        logic  rw;
    } redir_status_t;

endpackage
